// File: logic/rv_pkg.sv
package rv_pkg;

	// datapath widths
	localparam int XLEN       = 64;
	localparam int REG_ADDR_W = 5;
	localparam int STRB_W     = XLEN / 8; // one strobe bit per byte lane

	// alu operation select, carried from decode
	typedef enum logic [3:0] {
		ADD   = 4'd0,
		SUB   = 4'd1,
		AND   = 4'd2,
		OR    = 4'd3,
		XOR   = 4'd4,
		SLL   = 4'd5,
		SRL   = 4'd6,
		SRA   = 4'd7,
		SLT   = 4'd8,
		SLTU  = 4'd9,
		PASS2 = 4'd10 // src2 straight through, lui style
	} alu_op_t;

	// access size, same encoding as funct3[1:0]
	typedef enum logic [1:0] {
		BYTE  = 2'd0,
		HALF  = 2'd1,
		WORD  = 2'd2,
		DWORD = 2'd3
	} mem_size_t;

	// what the memory stage does with the op
	typedef enum logic [1:0] {
		NONE  = 2'd0,
		LOAD  = 2'd1,
		STORE = 2'd2
	} mem_kind_t;

endpackage

// File: logic/exec_alu.sv
`timescale 1ns/1ns

module exec_alu import rv_pkg::*; (
	input  alu_op_t         alu_op_i,
	input  logic [XLEN-1:0] src1_i,
	input  logic [XLEN-1:0] src2_i,
	output logic [XLEN-1:0] res_o
);

	logic [5:0] shamt; // rv64 shifts only look at 6 bits
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = src2_i[5:0];
	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	always_comb begin
		case (alu_op_i)
			ADD: begin
				res_o = src1_i + src2_i;
			end
			SUB: begin
				res_o = src1_i - src2_i;
			end
			AND: begin
				res_o = src1_i & src2_i;
			end
			OR: begin
				res_o = src1_i | src2_i;
			end
			XOR: begin
				res_o = src1_i ^ src2_i;
			end
			SLL: begin
				res_o = src1_i << shamt;
			end
			SRL: begin
				res_o = src1_i >> shamt;
			end
			SRA: begin
				res_o = $signed(src1_i) >>> shamt; // keeps the sign bit
			end
			SLT: begin
				res_o = {{(XLEN-1){1'b0}}, lt_signed};
			end
			SLTU: begin
				res_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			end
			PASS2: begin
				res_o = src2_i;
			end
			default: begin
				res_o = '0; // unused encodings
			end
		endcase
	end

endmodule

// File: logic/store_unit.sv
`timescale 1ns/1ns

module store_unit import rv_pkg::*; (
	input  logic [XLEN-1:0]   base_i,
	input  logic [31:0]       s_imm_i,
	input  mem_kind_t         kind_i,
	input  mem_size_t         size_i,
	input  logic [XLEN-1:0]   data_i,
	output logic [XLEN-1:0]   addr_o,
	output logic [STRB_W-1:0] wmask_o,
	output logic [XLEN-1:0]   wdata_o
);

	logic [XLEN-1:0]     sext_imm;
	logic [2:0]          byte_off;
	logic [STRB_W-1:0]   size_mask;
	logic [2*STRB_W-1:0] mask_rot;
	logic [2*XLEN-1:0]   data_rot;

	// effective address, offset sign extended to xlen
	assign sext_imm = {{(XLEN-32){s_imm_i[31]}}, s_imm_i};
	assign addr_o   = base_i + sext_imm;
	assign byte_off = addr_o[2:0];

	// lanes touched by an aligned access of this size
	always_comb begin
		case (size_i)
			BYTE:    size_mask = 8'b0000_0001;
			HALF:    size_mask = 8'b0000_0011;
			WORD:    size_mask = 8'b0000_1111;
			default: size_mask = 8'b1111_1111;
		endcase
	end

	// rotate left by the byte offset, so misaligned lanes wrap inside the doubleword
	assign mask_rot = {size_mask, size_mask} << byte_off;
	assign wmask_o  = (kind_i == STORE) ? mask_rot[2*STRB_W-1:STRB_W] : '0;

	// byte 0 of the store data lands on lane byte_off
	assign data_rot = {data_i, data_i} << {byte_off, 3'b000};
	assign wdata_o  = data_rot[2*XLEN-1:XLEN];

endmodule

// File: logic/ex_mem_regs.sv
`timescale 1ns/1ns

module ex_mem_regs import rv_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall_i,
	input  logic                  valid_i,
	input  logic                  reg_wen_i,
	input  logic [REG_ADDR_W-1:0] reg_waddr_i,
	input  logic [XLEN-1:0]       alu_res_i,
	input  logic [XLEN-1:0]       addr_i,
	input  logic [STRB_W-1:0]     wmask_i,
	input  logic [XLEN-1:0]       wdata_i,
	input  mem_kind_t             kind_i,
	input  mem_size_t             size_i,
	input  logic                  load_unsigned_i,
	input  logic                  ebreak_i,
	output logic                  valid_o,
	output logic                  reg_wen_o,
	output logic [REG_ADDR_W-1:0] reg_waddr_o,
	output logic [XLEN-1:0]       alu_res_o,
	output logic [XLEN-1:0]       addr_o,
	output logic [STRB_W-1:0]     wmask_o,
	output logic [XLEN-1:0]       wdata_o,
	output mem_kind_t             kind_o,
	output mem_size_t             size_o,
	output logic                  load_unsigned_o,
	output logic                  ebreak_o,
	output logic                  held_o // contents are a stall repeat
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_o         <= 1'b0;
			reg_wen_o       <= 1'b0;
			reg_waddr_o     <= '0;
			alu_res_o       <= '0;
			addr_o          <= '0;
			wmask_o         <= '0;
			wdata_o         <= '0;
			kind_o          <= NONE;
			size_o          <= BYTE;
			load_unsigned_o <= 1'b0;
			ebreak_o        <= 1'b0;
			held_o          <= 1'b0;
		end else if (stall_i) begin
			// every field keeps its value, mem stage must not redo the op
			held_o <= 1'b1;
		end else begin
			valid_o         <= valid_i;
			reg_wen_o       <= reg_wen_i;
			reg_waddr_o     <= reg_waddr_i;
			alu_res_o       <= alu_res_i;
			addr_o          <= addr_i;
			wmask_o         <= wmask_i;
			wdata_o         <= wdata_i;
			kind_o          <= kind_i;
			size_o          <= size_i;
			load_unsigned_o <= load_unsigned_i;
			ebreak_o        <= ebreak_i;
			held_o          <= 1'b0;
		end
	end

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/1ns

module mem_stage import rv_pkg::*; #(
	parameter int DMEM_AW = 6
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  held_i,
	input  logic                  valid_i,
	input  logic                  reg_wen_i,
	input  logic [REG_ADDR_W-1:0] reg_waddr_i,
	input  logic [XLEN-1:0]       alu_res_i,
	input  logic [XLEN-1:0]       addr_i,
	input  logic [STRB_W-1:0]     wmask_i,
	input  logic [XLEN-1:0]       wdata_i,
	input  mem_kind_t             kind_i,
	input  mem_size_t             size_i,
	input  logic                  load_unsigned_i,
	input  logic                  ebreak_i,
	output logic                  wb_valid_o,
	output logic [REG_ADDR_W-1:0] wb_waddr_o,
	output logic [XLEN-1:0]       wb_data_o,
	output logic                  halt_o
);

	logic [XLEN-1:0]    ram [2**DMEM_AW]; // doubleword wide data memory
	logic [DMEM_AW-1:0] word_idx;
	logic [XLEN-1:0]    rdata;
	logic [2*XLEN-1:0]  ld_rot;
	logic [XLEN-1:0]    ld_raw;
	logic [XLEN-1:0]    ld_ext;
	logic               commit;

	assign commit   = valid_i & ~held_i; // first pass only
	assign word_idx = addr_i[DMEM_AW+2:3];
	assign rdata    = ram[word_idx]; // async read

	// bring the addressed byte down to lane 0, wrapping like the store side
	assign ld_rot = {rdata, rdata} >> {addr_i[2:0], 3'b000};
	assign ld_raw = ld_rot[XLEN-1:0];

	always_comb begin
		case (size_i)
			BYTE:    ld_ext = {{(XLEN-8){ld_raw[7] & ~load_unsigned_i}}, ld_raw[7:0]};
			HALF:    ld_ext = {{(XLEN-16){ld_raw[15] & ~load_unsigned_i}}, ld_raw[15:0]};
			WORD:    ld_ext = {{(XLEN-32){ld_raw[31] & ~load_unsigned_i}}, ld_raw[31:0]};
			default: ld_ext = ld_raw;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**DMEM_AW; i++) begin
				ram[i] <= '0;
			end
		end else if (commit) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (wmask_i[b]) ram[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8]; // mask is 0 unless store
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_o <= 1'b0;
			halt_o     <= 1'b0;
		end else begin
			wb_valid_o <= commit & reg_wen_i; // single cycle pulse
			if (commit && ebreak_i) halt_o <= 1'b1; // sticky until reset
		end
	end

	// writeback payload
	always_ff @(posedge clk) begin
		if (commit) begin
			wb_waddr_o <= reg_waddr_i;
			wb_data_o  <= (kind_i == LOAD) ? ld_ext : alu_res_i;
		end
	end

endmodule

// File: logic/ex_mem_top.sv
`timescale 1ns/1ns

module ex_mem_top import rv_pkg::*; #(
	parameter int DMEM_AW = 6
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  valid_i,
	input  logic                  stall_i,
	input  alu_op_t               alu_op_i,
	input  logic [XLEN-1:0]       alu_src1_i,
	input  logic [XLEN-1:0]       alu_src2_i,
	input  logic [31:0]           s_imm_i,
	input  mem_kind_t             mem_kind_i,
	input  mem_size_t             mem_size_i,
	input  logic                  load_unsigned_i,
	input  logic                  reg_wen_i,
	input  logic [REG_ADDR_W-1:0] reg_waddr_i,
	input  logic                  ebreak_i,
	output logic                  wb_valid_o,
	output logic [REG_ADDR_W-1:0] wb_waddr_o,
	output logic [XLEN-1:0]       wb_data_o,
	output logic                  halt_o
);

	// execute stage results
	logic [XLEN-1:0]       alu_res;
	logic [XLEN-1:0]       eff_addr;
	logic [STRB_W-1:0]     wmask;
	logic [XLEN-1:0]       store_data;

	// ex/mem register outputs
	logic                  held;
	logic                  mem_valid;
	logic                  mem_reg_wen;
	logic [REG_ADDR_W-1:0] mem_reg_waddr;
	logic [XLEN-1:0]       mem_alu_res;
	logic [XLEN-1:0]       mem_addr;
	logic [STRB_W-1:0]     mem_wmask;
	logic [XLEN-1:0]       mem_wdata;
	mem_kind_t             mem_kind;
	mem_size_t             mem_size;
	logic                  mem_load_unsigned;
	logic                  mem_ebreak;

	exec_alu exec_alu_inst (
		.alu_op_i (alu_op_i),
		.src1_i   (alu_src1_i),
		.src2_i   (alu_src2_i),
		.res_o    (alu_res)
	);

	// rs1 is the base, rs2 the store data
	store_unit store_unit_inst (
		.base_i  (alu_src1_i),
		.s_imm_i (s_imm_i),
		.kind_i  (mem_kind_i),
		.size_i  (mem_size_i),
		.data_i  (alu_src2_i),
		.addr_o  (eff_addr),
		.wmask_o (wmask),
		.wdata_o (store_data)
	);

	ex_mem_regs ex_mem_regs_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.stall_i         (stall_i),
		.valid_i         (valid_i),
		.reg_wen_i       (reg_wen_i),
		.reg_waddr_i     (reg_waddr_i),
		.alu_res_i       (alu_res),
		.addr_i          (eff_addr),
		.wmask_i         (wmask),
		.wdata_i         (store_data),
		.kind_i          (mem_kind_i),
		.size_i          (mem_size_i),
		.load_unsigned_i (load_unsigned_i),
		.ebreak_i        (ebreak_i),
		.valid_o         (mem_valid),
		.reg_wen_o       (mem_reg_wen),
		.reg_waddr_o     (mem_reg_waddr),
		.alu_res_o       (mem_alu_res),
		.addr_o          (mem_addr),
		.wmask_o         (mem_wmask),
		.wdata_o         (mem_wdata),
		.kind_o          (mem_kind),
		.size_o          (mem_size),
		.load_unsigned_o (mem_load_unsigned),
		.ebreak_o        (mem_ebreak),
		.held_o          (held)
	);

	mem_stage #(
		.DMEM_AW (DMEM_AW)
	) mem_stage_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.held_i          (held),
		.valid_i         (mem_valid),
		.reg_wen_i       (mem_reg_wen),
		.reg_waddr_i     (mem_reg_waddr),
		.alu_res_i       (mem_alu_res),
		.addr_i          (mem_addr),
		.wmask_i         (mem_wmask),
		.wdata_i         (mem_wdata),
		.kind_i          (mem_kind),
		.size_i          (mem_size),
		.load_unsigned_i (mem_load_unsigned),
		.ebreak_i        (mem_ebreak),
		.wb_valid_o      (wb_valid_o),
		.wb_waddr_o      (wb_waddr_o),
		.wb_data_o       (wb_data_o),
		.halt_o          (halt_o)
	);

endmodule

// File: tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// shadow of the data RAM, one doubleword per entry
logic [XLEN-1:0] shadow_mem [2**DMEM_AW];

function automatic logic [XLEN-1:0] ref_alu(alu_op_t op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
	case (op)
		ADD:     return a + b;
		SUB:     return a - b;
		AND:     return a & b;
		OR:      return a | b;
		XOR:     return a ^ b;
		SLL:     return a << b[5:0];
		SRL:     return a >> b[5:0];
		SRA:     return $signed(a) >>> b[5:0];
		SLT:     return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
		SLTU:    return (a < b) ? 64'd1 : 64'd0;
		PASS2:   return b;
		default: return '0;
	endcase
endfunction

// byte i of the data goes to lane (addr + i) mod 8 of the same doubleword
function automatic void ref_store(logic [XLEN-1:0] addr, mem_size_t size, logic [XLEN-1:0] data);
	int n;
	int lane;
	logic [DMEM_AW-1:0] w;
	n = 1 << size;
	w = addr[DMEM_AW+2:3];
	for (int i = 0; i < n; i++) begin
		lane = (addr[2:0] + i) % 8;
		shadow_mem[w][lane*8 +: 8] = data[i*8 +: 8];
	end
endfunction

function automatic logic [XLEN-1:0] ref_load(logic [XLEN-1:0] addr, mem_size_t size, logic uns);
	int n;
	int lane;
	logic [DMEM_AW-1:0] w;
	logic [XLEN-1:0] val;
	n = 1 << size;
	w = addr[DMEM_AW+2:3];
	val = '0;
	for (int i = 0; i < n; i++) begin
		lane = (addr[2:0] + i) % 8;
		val[i*8 +: 8] = shadow_mem[w][lane*8 +: 8];
	end
	if (!uns && n < 8 && val[n*8-1]) val = val | ~((64'd1 << (n*8)) - 64'd1); // sign fill
	return val;
endfunction

`endif

// File: tests/tb_ex_mem.sv
`timescale 1ns/1ns

module tb_ex_mem import rv_pkg::*; ();

	localparam int DMEM_AW = 6;

	logic                  clk;
	logic                  rst_n;
	logic                  valid_i;
	logic                  stall_i;
	alu_op_t               alu_op_i;
	logic [XLEN-1:0]       alu_src1_i;
	logic [XLEN-1:0]       alu_src2_i;
	logic [31:0]           s_imm_i;
	mem_kind_t             mem_kind_i;
	mem_size_t             mem_size_i;
	logic                  load_unsigned_i;
	logic                  reg_wen_i;
	logic [REG_ADDR_W-1:0] reg_waddr_i;
	logic                  ebreak_i;
	logic                  wb_valid_o;
	logic [REG_ADDR_W-1:0] wb_waddr_o;
	logic [XLEN-1:0]       wb_data_o;
	logic                  halt_o;

	integer seed;
	int     cycle;
	logic   stall_en;   // random stall bursts on/off
	logic   halt_armed; // an ebreak has been accepted
	logic   halt_seen;

	// expected writebacks, oldest first
	logic [REG_ADDR_W-1:0] exp_rd[$];
	logic [XLEN-1:0]       exp_data[$];
	int                    exp_cycle[$];
	logic                  exp_exact[$]; // latency must be exactly 2

	`include "tb_ref_model.svh"

	ex_mem_top #(
		.DMEM_AW (DMEM_AW)
	) ex_mem_top_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.valid_i         (valid_i),
		.stall_i         (stall_i),
		.alu_op_i        (alu_op_i),
		.alu_src1_i      (alu_src1_i),
		.alu_src2_i      (alu_src2_i),
		.s_imm_i         (s_imm_i),
		.mem_kind_i      (mem_kind_i),
		.mem_size_i      (mem_size_i),
		.load_unsigned_i (load_unsigned_i),
		.reg_wen_i       (reg_wen_i),
		.reg_waddr_i     (reg_waddr_i),
		.ebreak_i        (ebreak_i),
		.wb_valid_o      (wb_valid_o),
		.wb_waddr_o      (wb_waddr_o),
		.wb_data_o       (wb_data_o),
		.halt_o          (halt_o)
	);

	always #10 clk = ~clk;

	always @(negedge clk) cycle <= cycle + 1; // stable count at each rising edge

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "stopping at first error");
	endtask

	task automatic mismatch(input string name, input logic [XLEN-1:0] exp,
			input logic [XLEN-1:0] got);
		stop_on_error($sformatf("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	function automatic logic [XLEN-1:0] rand_dword();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic pick_stall();
		return stall_en && (($random(seed) & 3) == 0);
	endfunction

	// writeback and halt checking at every rising edge
	always @(posedge clk) begin
		if (rst_n) begin
			if (wb_valid_o) begin
				assert (exp_data.size() > 0)
					else stop_on_error("writeback pulse with no operation outstanding");
				assert (wb_waddr_o == exp_rd[0])
					else mismatch("wb_waddr_o", XLEN'(exp_rd[0]), XLEN'(wb_waddr_o));
				assert (wb_data_o == exp_data[0])
					else mismatch("wb_data_o", exp_data[0], wb_data_o);
				assert (!exp_exact[0] || cycle - exp_cycle[0] == 2)
					else stop_on_error("writeback did not arrive two cycles after issue");
				void'(exp_rd.pop_front());
				void'(exp_data.pop_front());
				void'(exp_cycle.pop_front());
				void'(exp_exact.pop_front());
			end
			assert (!halt_o || halt_armed) else mismatch("halt_o", XLEN'(0), XLEN'(halt_o));
			assert (!halt_seen || halt_o) else mismatch("halt_o", XLEN'(1), XLEN'(halt_o));
			if (halt_o) halt_seen = 1'b1;
		end
	end

	// present one op and hold it until an edge accepts it
	task automatic issue(input alu_op_t op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
			input logic [31:0] imm, input mem_kind_t kind, input mem_size_t size,
			input logic uns, input logic wen, input logic [REG_ADDR_W-1:0] rd, input logic brk);
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] res;
		int waits;
		alu_op_i        = op;
		alu_src1_i      = a;
		alu_src2_i      = b;
		s_imm_i         = imm;
		mem_kind_i      = kind;
		mem_size_i      = size;
		load_unsigned_i = uns;
		reg_wen_i       = wen;
		reg_waddr_i     = rd;
		ebreak_i        = brk;
		valid_i         = 1'b1;
		stall_i         = pick_stall();
		waits = 0;
		@(posedge clk);
		while (stall_i) begin
			waits++;
			if (waits > 50) stop_on_error("op was never accepted, stall did not clear");
			#2 stall_i = pick_stall();
			@(posedge clk);
		end
		addr = a + {{32{imm[31]}}, imm};
		res = (kind == LOAD) ? ref_load(addr, size, uns) : ref_alu(op, a, b);
		if (kind == STORE) ref_store(addr, size, b);
		if (wen) begin
			exp_rd.push_back(rd);
			exp_data.push_back(res);
			exp_cycle.push_back(cycle);
			exp_exact.push_back(!stall_en);
		end
		if (brk) halt_armed = 1'b1;
		#2;
		valid_i  = 1'b0;
		ebreak_i = 1'b0;
		stall_i  = pick_stall();
	endtask

	initial begin
		logic [XLEN-1:0] base;
		logic [31:0]     imm;
		int              waits;
		seed = 77;
		clk = 1'b0;
		rst_n = 1'b0;
		cycle = 0;
		stall_en = 1'b0;
		halt_armed = 1'b0;
		halt_seen = 1'b0;
		valid_i = 1'b0;
		stall_i = 1'b0;
		alu_op_i = ADD;
		alu_src1_i = '0;
		alu_src2_i = '0;
		s_imm_i = '0;
		mem_kind_i = NONE;
		mem_size_i = BYTE;
		load_unsigned_i = 1'b0;
		reg_wen_i = 1'b0;
		reg_waddr_i = '0;
		ebreak_i = 1'b0;
		for (int i = 0; i < 2**DMEM_AW; i++) shadow_mem[i] = '0;
		repeat (5) @(posedge clk);
		#2 rst_n = 1'b1;
		repeat (3) @(posedge clk); // outputs must stay quiet here
		#2;

		// every alu opcode, no stalls, one op per group without writeback
		for (int i = 0; i <= 10; i++) begin
			for (int j = 0; j < 4; j++) begin
				issue(alu_op_t'(i), rand_dword(), rand_dword(), $random(seed), NONE, BYTE, 1'b0,
					j != 3, REG_ADDR_W'($random(seed)), 1'b0);
			end
		end

		// stores then loads of each size, stall bursts from here on
		stall_en = 1'b1;
		for (int sz = 0; sz < 4; sz++) begin
			for (int k = 0; k < 6; k++) begin
				base = rand_dword();
				imm  = $random(seed) & 32'h0000_01ff;
				if (k[0]) imm = -imm; // negative offsets too
				issue(ADD, base, rand_dword(), imm, STORE, mem_size_t'(sz), 1'b0, 1'b0, 5'd0, 1'b0);
				for (int l = 0; l < 4; l++) begin
					issue(ADD, base, '0, imm, LOAD, mem_size_t'(l), l[0], 1'b1,
						REG_ADDR_W'($random(seed)), 1'b0);
				end
			end
		end

		// random mix under stall
		for (int n = 0; n < 40; n++) begin
			issue(alu_op_t'($unsigned($random(seed)) % 11), rand_dword(), rand_dword(),
				$random(seed), mem_kind_t'($unsigned($random(seed)) % 3),
				mem_size_t'($random(seed) & 3), 1'($random(seed)), 1'($random(seed)),
				REG_ADDR_W'($random(seed)), 1'b0);
		end

		stall_en = 1'b0;
		stall_i = 1'b0;
		waits = 0;
		while (exp_data.size() != 0) begin
			waits++;
			if (waits > 100) stop_on_error("outstanding writebacks never arrived");
			@(posedge clk);
		end
		#2;

		// ebreak sets a sticky halt
		issue(ADD, '0, '0, '0, NONE, BYTE, 1'b0, 1'b0, 5'd0, 1'b1);
		waits = 0;
		while (!halt_o) begin
			waits++;
			if (waits > 20) stop_on_error("halt_o never rose after ebreak");
			@(posedge clk);
		end
		repeat (10) @(posedge clk);

		$display("All tests passed!");
		$finish;
	end

endmodule

// File: all.f
+incdir+tests
logic/rv_pkg.sv
logic/exec_alu.sv
logic/store_unit.sv
logic/ex_mem_regs.sv
logic/mem_stage.sv
logic/ex_mem_top.sv
tests/tb_ex_mem.sv

// File: run.sh
#!/bin/sh
# build and run the ex/mem slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_ex_mem -f all.f -o sim_ex_mem
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/sim_ex_mem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1
